//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= mini_pipe_top.f
RTL_TOP   ?= mini_pipe_top
TB_TOP    ?= tb_mini_pipe
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_mini_pipe.sv
// Testbench for the RV32I execution slice
// Random instructions over APB, checked against a register model
`timescale 1ns/100ps

module tb_mini_pipe import pipe_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int APB_AW     = 8;
    localparam int NUM_RANDOM = 200;
    localparam int WAIT_LIMIT = 20;

    logic              clk, arst_n_i, psel_i, penable_i, pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [31:0]       pwdata_i, prdata_o;
    logic              pready_o, pslverr_o;

    logic [31:0] model_regs [32];
    logic [31:0] model_retired;
    logic        model_illegal;
    logic [31:0] lfsr_state;

    mini_pipe_top #(.APB_AW(APB_AW)) mini_pipe_top_i (
        .clk, .arst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("MISMATCH %s: expected 0x%08h actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        while (pready_o !== 1'b1) begin
            if (waited >= WAIT_LIMIT) fail_run("APB write never saw pready");
            waited++;
            @(negedge clk);
        end
        err = pslverr_o;  // sampled mid-cycle, before the completing edge
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        while (pready_o !== 1'b1) begin
            if (waited >= WAIT_LIMIT) fail_run("APB read never saw pready");
            waited++;
            @(negedge clk);
        end
        data = prdata_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    // kinds 0..4 are R-type, 5..8 are I-type, 9 is LUI
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd, rs1, rs2,
                                           input logic [19:0] imm);
        case (kind)
            0:       return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};  // add
            1:       return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};  // sub
            2:       return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};  // and
            3:       return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};  // or
            4:       return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};  // xor
            5:       return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};   // addi
            6:       return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};   // andi
            7:       return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};   // ori
            8:       return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};   // xori
            default: return {imm, rd, 7'b0110111};                      // lui
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input int kind, input logic [31:0] a, b,
                                                    input logic [19:0] imm);
        logic [31:0] simm;
        simm = {{20{imm[11]}}, imm[11:0]};
        case (kind)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return a + simm;
            6:       return a & simm;
            7:       return a | simm;
            8:       return a ^ simm;
            default: return {imm, 12'h000};
        endcase
    endfunction

    task automatic read_gpr_check(input logic [4:0] n, input string name);
        logic [31:0] data;
        apb_read(REG_GPR_BASE + {1'b0, n, 2'b00}, data);
        check(name, model_regs[n], data);
    endtask

    task automatic check_all_gprs(input string name);
        for (int n = 0; n < 32; n++) read_gpr_check(5'(n), name);
    endtask

    task automatic read_reg_check(input logic [APB_AW-1:0] addr, input logic [31:0] expected,
                                  input string name);
        logic [31:0] data;
        apb_read(addr, data);
        check(name, expected, data);
    endtask

    task automatic run_legal(input int kind, input logic [4:0] rd, rs1, rs2,
                             input logic [19:0] imm);
        logic [31:0] result;
        logic        err;
        result = expected_result(kind, model_regs[rs1], model_regs[rs2], imm);
        apb_write(REG_INSTR, encode(kind, rd, rs1, rs2, imm), err);
        check("issue accepted", 32'd0, {31'b0, err});
        if (rd != 5'd0) model_regs[rd] = result;  // x0 stays zero
        model_retired = model_retired + 32'd1;
        read_gpr_check(rd, "random alu");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] fields;
        logic [19:0] imm;
        logic [4:0]  rd_a, rd_b;
        logic [6:0]  opc;
        logic        err;
        int          kind;
        arst_n_i  <= 1'b0;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= '0;
        pwdata_i  <= '0;
        lfsr_state    = 32'ha824c9be;
        model_retired = '0;
        model_illegal = 1'b0;
        for (int n = 0; n < 32; n++) model_regs[n] = '0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;

        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(4, r);
            kind = int'(r[3:0]) % 10;
            take_bits(15, fields);  // rd, rs1, rs2
            take_bits(20, r);
            run_legal(kind, fields[14:10], fields[9:5], fields[4:0], r[19:0]);
        end
        read_reg_check(REG_RETIRED, model_retired, "retired count");

        // illegal opcode must retire nothing
        take_bits(32, r);
        opc = r[6:0];
        if (opc == 7'b0110011 || opc == 7'b0010011 || opc == 7'b0110111) opc = 7'b1111111;
        apb_write(REG_INSTR, {r[31:7], opc}, err);
        check("illegal issue", 32'd0, {31'b0, err});
        model_illegal = 1'b1;
        check_all_gprs("illegal keeps gprs");
        read_reg_check(REG_STATUS, {31'b0, model_illegal}, "illegal sticky");
        apb_write(REG_STATUS, 32'd1, err);
        model_illegal = 1'b0;
        read_reg_check(REG_STATUS, {31'b0, model_illegal}, "illegal cleared");
        read_reg_check(REG_RETIRED, model_retired, "retired after illegal");

        // halt with one instruction held in the slot
        take_bits(4, r);
        rd_a = {1'b0, r[3:0]} | 5'd1;
        rd_b = rd_a + 5'd16;
        take_bits(12, r);
        imm  = {8'h00, r[11:0] | 12'h001};  // nonzero so a double retire shows
        apb_write(REG_CTRL, 32'd1, err);
        apb_write(REG_INSTR, encode(5, rd_a, rd_a, 5'd0, imm), err);
        check("halt issue", 32'd0, {31'b0, err});
        apb_write(REG_INSTR, encode(5, rd_b, rd_b, 5'd0, imm), err);
        check("busy slot refused", 32'd1, {31'b0, err});
        read_gpr_check(rd_a, "halted dest");
        apb_write(REG_CTRL, 32'd0, err);
        model_regs[rd_a] = expected_result(5, model_regs[rd_a], 32'd0, imm);
        model_retired    = model_retired + 32'd1;
        read_gpr_check(rd_a, "released dest");
        read_gpr_check(rd_b, "refused dest");
        read_reg_check(REG_RETIRED, model_retired, "retired after halt");

        // flush the held instruction while releasing halt
        apb_write(REG_CTRL, 32'd1, err);
        apb_write(REG_INSTR, encode(5, rd_a, rd_a, 5'd0, imm), err);
        check("flush issue", 32'd0, {31'b0, err});
        apb_write(REG_CTRL, 32'd2, err);
        read_gpr_check(rd_a, "flushed dest");
        read_reg_check(REG_STATUS, {31'b0, model_illegal}, "slot empty after flush");
        read_reg_check(REG_RETIRED, model_retired, "retired after flush");

        // retired count is read only
        apb_write(REG_RETIRED, 32'hFFFF_FFFF, err);
        check("retired write refused", 32'd1, {31'b0, err});
        read_reg_check(REG_RETIRED, model_retired, "retired unchanged");
        check_all_gprs("final gprs");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- hw/apb_ctrl_regs.sv
// APB slave for the execution slice
// Holds halt/flush control, sticky status and the retired counter, and issues instructions
`timescale 1ns/100ps

module apb_ctrl_regs import pipe_pkg::*; #(
    parameter int APB_AW = 8
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [APB_AW-1:0]         paddr_i,
    input  logic [INST_WIDTH-1:0]     pwdata_i,
    output logic [INST_WIDTH-1:0]     prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  logic                      slot_busy_i,
    input  logic                      retire_pulse_i,
    input  logic                      illegal_pulse_i,
    input  logic [INST_WIDTH-1:0]     host_rdata_i,
    output logic                      issue_valid_o,
    output logic [INST_WIDTH-1:0]     issue_inst_o,
    output logic [CU_BUS_WIDTH-1:0]   stall_flag_o,
    output logic [REG_ADDR_WIDTH-1:0] host_raddr_o
);

    logic                  halt_q;
    logic                  flush_q;
    logic                  illegal_q;
    logic [INST_WIDTH-1:0] retired_q;
    logic                  wr_en;
    logic                  sel_ctrl, sel_instr, sel_status, sel_retired, sel_gpr;

    assign wr_en       = psel_i & penable_i & pwrite_i;  // access phase, pready always 1
    assign sel_ctrl    = (paddr_i == APB_AW'(REG_CTRL));
    assign sel_instr   = (paddr_i == APB_AW'(REG_INSTR));
    assign sel_status  = (paddr_i == APB_AW'(REG_STATUS));
    assign sel_retired = (paddr_i == APB_AW'(REG_RETIRED));
    assign sel_gpr     = ((paddr_i & ~APB_AW'(8'h7F)) == APB_AW'(REG_GPR_BASE));

    assign pready_o     = 1'b1;
    assign issue_valid_o = wr_en & sel_instr & ~slot_busy_i;
    assign issue_inst_o  = pwdata_i;
    assign stall_flag_o  = {flush_q, halt_q};
    assign host_raddr_o  = paddr_i[REG_ADDR_WIDTH+1:2];  // word index inside the GPR window

    // busy slot or a read-only/unmapped target
    assign pslverr_o = wr_en & ((sel_instr & slot_busy_i) | ~(sel_ctrl | sel_instr | sel_status));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            halt_q    <= 1'b0;
            flush_q   <= 1'b0;
            illegal_q <= 1'b0;
            retired_q <= '0;
        end else begin
            flush_q <= wr_en & sel_ctrl & pwdata_i[1];  // single-cycle pulse
            if (wr_en && sel_ctrl) begin
                halt_q <= pwdata_i[0];
            end
            if (illegal_pulse_i) begin
                illegal_q <= 1'b1;  // a new event wins over the clear
            end else if (wr_en && sel_status && pwdata_i[0]) begin
                illegal_q <= 1'b0;
            end
            retired_q <= retired_q + INST_WIDTH'(retire_pulse_i);
        end
    end

    always_comb begin
        prdata_o = '0;
        if (sel_ctrl)         prdata_o[0] = halt_q;
        else if (sel_status)  prdata_o[1:0] = {slot_busy_i, illegal_q};
        else if (sel_retired) prdata_o = retired_q;
        else if (sel_gpr)     prdata_o = host_rdata_i;
    end

    // an accepted issue finds the slot empty and fills it by the next cycle
    assert property (@(posedge clk) disable iff (!arst_n_i)
        issue_valid_o |-> !slot_busy_i ##1 slot_busy_i);

endmodule

//--- hw/exu_alu_wb.sv
// Execute stage: operand read, ALU and writeback
// Raises one registered pulse per retired or illegal instruction
`timescale 1ns/100ps

module exu_alu_wb import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [CU_BUS_WIDTH-1:0]   stall_flag_i,
    input  logic                      inst_valid_i,
    input  logic                      illegal_inst_i,
    input  logic                      reg_we_i,
    input  logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_raddr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_raddr_i,
    input  logic [DECINFO_WIDTH-1:0]  dec_info_bus_i,
    input  logic [INST_WIDTH-1:0]     dec_imm_i,
    input  logic [INST_WIDTH-1:0]     rs1_rdata_i,
    input  logic [INST_WIDTH-1:0]     rs2_rdata_i,
    output logic [REG_ADDR_WIDTH-1:0] rf_rs1_raddr_o,
    output logic [REG_ADDR_WIDTH-1:0] rf_rs2_raddr_o,
    output logic                      rf_we_o,
    output logic [REG_ADDR_WIDTH-1:0] rf_waddr_o,
    output logic [INST_WIDTH-1:0]     rf_wdata_o,
    output logic                      retire_pulse_o,
    output logic                      illegal_pulse_o
);

    alu_op_e               alu_op;
    logic [INST_WIDTH-1:0] op_b;
    logic                  act_en;

    assign alu_op = alu_op_e'(dec_info_bus_i[DEC_USE_IMM-1:0]);
    assign op_b   = dec_info_bus_i[DEC_USE_IMM] ? dec_imm_i : rs2_rdata_i;
    // held content acts once, after the stall drops
    assign act_en = inst_valid_i & ~stall_flag_i[CU_STALL] & ~stall_flag_i[CU_FLUSH];

    always_comb begin
        case (alu_op)
            OP_SUB:  rf_wdata_o = rs1_rdata_i - op_b;
            OP_AND:  rf_wdata_o = rs1_rdata_i & op_b;
            OP_OR:   rf_wdata_o = rs1_rdata_i | op_b;
            OP_XOR:  rf_wdata_o = rs1_rdata_i ^ op_b;
            OP_LUI:  rf_wdata_o = dec_imm_i;
            default: rf_wdata_o = rs1_rdata_i + op_b;
        endcase
    end

    assign rf_rs1_raddr_o = rs1_raddr_i;
    assign rf_rs2_raddr_o = rs2_raddr_i;
    assign rf_waddr_o     = reg_waddr_i;
    assign rf_we_o        = act_en & reg_we_i;  // reg_we is only set for legal instructions

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_pulse_o  <= 1'b0;
            illegal_pulse_o <= 1'b0;
        end else begin
            retire_pulse_o  <= rf_we_o;
            illegal_pulse_o <= act_en & illegal_inst_i;
        end
    end

    // decode never marks an instruction both writing and illegal
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(retire_pulse_o && illegal_pulse_o));

endmodule

//--- hw/gpr_regfile.sv
// 32x32 general register file with x0 hardwired to zero
// Two execute read ports, one host read port, one write port
`timescale 1ns/100ps

module gpr_regfile import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_raddr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_raddr_i,
    input  logic [REG_ADDR_WIDTH-1:0] host_raddr_i,
    input  logic                      we_i,
    input  logic [REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [INST_WIDTH-1:0]     wdata_i,
    output logic [INST_WIDTH-1:0]     rs1_rdata_o,
    output logic [INST_WIDTH-1:0]     rs2_rdata_o,
    output logic [INST_WIDTH-1:0]     host_rdata_o
);

    logic [INST_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) regs[i] <= '0;
        end else if (we_i && (waddr_i != '0)) begin  // x0 ignores writes
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rs1_rdata_o  = (rs1_raddr_i == '0) ? '0 : regs[rs1_raddr_i];
    assign rs2_rdata_o  = (rs2_raddr_i == '0) ? '0 : regs[rs2_raddr_i];
    assign host_rdata_o = (host_raddr_i == '0) ? '0 : regs[host_raddr_i];

endmodule

//--- hw/idu_decode.sv
// Issue slot and decoder for the RV32I subset
// Holds one instruction word and decodes OP, OP-IMM and LUI into execute fields
`timescale 1ns/100ps

module idu_decode import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      issue_valid_i,
    input  logic [INST_WIDTH-1:0]     issue_inst_i,
    input  logic [CU_BUS_WIDTH-1:0]   stall_flag_i,
    output logic                      slot_busy_o,
    output logic                      inst_valid_o,
    output logic                      illegal_inst_o,
    output logic                      reg_we_o,
    output logic [REG_ADDR_WIDTH-1:0] reg_waddr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs1_raddr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs2_raddr_o,
    output logic [DECINFO_WIDTH-1:0]  dec_info_bus_o,
    output logic [INST_WIDTH-1:0]     dec_imm_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic                  slot_valid;
    logic [INST_WIDTH-1:0] slot_inst;  // payload, no reset needed
    logic                  legal;
    logic                  use_imm;
    alu_op_e               alu_op;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid <= 1'b0;
        end else if (stall_flag_i[CU_FLUSH]) begin
            slot_valid <= 1'b0;
        end else if (issue_valid_i) begin
            slot_valid <= 1'b1;
        end else if (!stall_flag_i[CU_STALL]) begin
            slot_valid <= 1'b0;  // moved on into the pipe register
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) slot_inst <= issue_inst_i;
    end

    always_comb begin
        legal     = 1'b1;
        use_imm   = 1'b0;
        alu_op    = OP_ADD;
        dec_imm_o = '0;
        case (slot_inst[6:0])
            OPC_OP: begin
                case ({slot_inst[31:25], slot_inst[14:12]})
                    {7'h00, 3'b000}: alu_op = OP_ADD;
                    {7'h20, 3'b000}: alu_op = OP_SUB;
                    {7'h00, 3'b100}: alu_op = OP_XOR;
                    {7'h00, 3'b110}: alu_op = OP_OR;
                    {7'h00, 3'b111}: alu_op = OP_AND;
                    default:         legal  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                dec_imm_o = {{20{slot_inst[31]}}, slot_inst[31:20]};  // sign-extended I-type
                case (slot_inst[14:12])
                    3'b000:  alu_op = OP_ADD;
                    3'b100:  alu_op = OP_XOR;
                    3'b110:  alu_op = OP_OR;
                    3'b111:  alu_op = OP_AND;
                    default: legal  = 1'b0;  // shifts and compares not supported
                endcase
            end
            OPC_LUI: begin
                use_imm   = 1'b1;
                alu_op    = OP_LUI;
                dec_imm_o = {slot_inst[31:12], 12'h000};
            end
            default: legal = 1'b0;
        endcase
    end

    assign slot_busy_o    = slot_valid;
    assign inst_valid_o   = slot_valid;
    assign illegal_inst_o = slot_valid & ~legal;
    assign reg_we_o       = slot_valid & legal;
    assign reg_waddr_o    = slot_inst[11:7];
    assign rs1_raddr_o    = slot_inst[19:15];
    assign rs2_raddr_o    = slot_inst[24:20];
    assign dec_info_bus_o = {use_imm, alu_op};

endmodule

//--- hw/idu_id_pipe.sv
// Decode-to-execute pipeline register
// Holds its fields while stalled and loads zeros on a flush
`timescale 1ns/100ps

module idu_id_pipe import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [CU_BUS_WIDTH-1:0]   stall_flag_i,
    input  logic                      inst_valid_i,
    input  logic                      illegal_inst_i,
    input  logic                      reg_we_i,
    input  logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_raddr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_raddr_i,
    input  logic [DECINFO_WIDTH-1:0]  dec_info_bus_i,
    input  logic [INST_WIDTH-1:0]     dec_imm_i,
    output logic                      inst_valid_o,
    output logic                      illegal_inst_o,
    output logic                      reg_we_o,
    output logic [REG_ADDR_WIDTH-1:0] reg_waddr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs1_raddr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs2_raddr_o,
    output logic [DECINFO_WIDTH-1:0]  dec_info_bus_o,
    output logic [INST_WIDTH-1:0]     dec_imm_o
);

    localparam int PIPE_W = 3 + 3 * REG_ADDR_WIDTH + DECINFO_WIDTH + INST_WIDTH;

    logic              flush_en, stall_en;
    logic [PIPE_W-1:0] pipe_d, pipe_q;

    assign flush_en = stall_flag_i[CU_FLUSH];
    assign stall_en = stall_flag_i[CU_STALL];

    // register addresses travel, operands are read in execute
    assign pipe_d = flush_en ? '0 : {inst_valid_i, illegal_inst_i, reg_we_i, reg_waddr_i,
                                     rs1_raddr_i, rs2_raddr_i, dec_info_bus_i, dec_imm_i};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pipe_q <= '0;
        end else if (flush_en || !stall_en) begin  // flush wins over stall
            pipe_q <= pipe_d;
        end
    end

    assign {inst_valid_o, illegal_inst_o, reg_we_o, reg_waddr_o,
            rs1_raddr_o, rs2_raddr_o, dec_info_bus_o, dec_imm_o} = pipe_q;

    assert property (@(posedge clk) disable iff (!arst_n_i)
        (stall_en && !flush_en) |=> $stable(pipe_q));

endmodule

//--- hw/mini_pipe_top.sv
// Top level of the RV32I execution slice
// APB register block feeding decode, pipe register, execute and register file
`timescale 1ns/100ps

module mini_pipe_top import pipe_pkg::*; #(
    parameter int APB_AW = 8
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_AW-1:0]     paddr_i,
    input  logic [INST_WIDTH-1:0] pwdata_i,
    output logic [INST_WIDTH-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    logic                      issue_valid, slot_busy, retire_pulse, illegal_pulse;
    logic [INST_WIDTH-1:0]     issue_inst, host_rdata;
    logic [CU_BUS_WIDTH-1:0]   stall_flag;
    logic [REG_ADDR_WIDTH-1:0] host_raddr;

    // decode side
    logic                      d_valid, d_illegal, d_we;
    logic [REG_ADDR_WIDTH-1:0] d_waddr, d_rs1, d_rs2;
    logic [DECINFO_WIDTH-1:0]  d_info;
    logic [INST_WIDTH-1:0]     d_imm;

    // execute side
    logic                      e_valid, e_illegal, e_we;
    logic [REG_ADDR_WIDTH-1:0] e_waddr, e_rs1, e_rs2;
    logic [DECINFO_WIDTH-1:0]  e_info;
    logic [INST_WIDTH-1:0]     e_imm;

    // register file ports
    logic                      rf_we;
    logic [REG_ADDR_WIDTH-1:0] rf_rs1, rf_rs2, rf_waddr;
    logic [INST_WIDTH-1:0]     rf_wdata, rs1_rdata, rs2_rdata;

    apb_ctrl_regs #(.APB_AW(APB_AW)) apb_ctrl_regs_i (
        .clk, .arst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .slot_busy_i(slot_busy), .retire_pulse_i(retire_pulse),
        .illegal_pulse_i(illegal_pulse), .host_rdata_i(host_rdata),
        .issue_valid_o(issue_valid), .issue_inst_o(issue_inst),
        .stall_flag_o(stall_flag), .host_raddr_o(host_raddr)
    );

    idu_decode idu_decode_i (
        .clk, .arst_n_i, .issue_valid_i(issue_valid), .issue_inst_i(issue_inst),
        .stall_flag_i(stall_flag), .slot_busy_o(slot_busy),
        .inst_valid_o(d_valid), .illegal_inst_o(d_illegal), .reg_we_o(d_we),
        .reg_waddr_o(d_waddr), .rs1_raddr_o(d_rs1), .rs2_raddr_o(d_rs2),
        .dec_info_bus_o(d_info), .dec_imm_o(d_imm)
    );

    idu_id_pipe idu_id_pipe_i (
        .clk, .arst_n_i, .stall_flag_i(stall_flag),
        .inst_valid_i(d_valid), .illegal_inst_i(d_illegal), .reg_we_i(d_we),
        .reg_waddr_i(d_waddr), .rs1_raddr_i(d_rs1), .rs2_raddr_i(d_rs2),
        .dec_info_bus_i(d_info), .dec_imm_i(d_imm),
        .inst_valid_o(e_valid), .illegal_inst_o(e_illegal), .reg_we_o(e_we),
        .reg_waddr_o(e_waddr), .rs1_raddr_o(e_rs1), .rs2_raddr_o(e_rs2),
        .dec_info_bus_o(e_info), .dec_imm_o(e_imm)
    );

    exu_alu_wb exu_alu_wb_i (
        .clk, .arst_n_i, .stall_flag_i(stall_flag),
        .inst_valid_i(e_valid), .illegal_inst_i(e_illegal), .reg_we_i(e_we),
        .reg_waddr_i(e_waddr), .rs1_raddr_i(e_rs1), .rs2_raddr_i(e_rs2),
        .dec_info_bus_i(e_info), .dec_imm_i(e_imm),
        .rs1_rdata_i(rs1_rdata), .rs2_rdata_i(rs2_rdata),
        .rf_rs1_raddr_o(rf_rs1), .rf_rs2_raddr_o(rf_rs2), .rf_we_o(rf_we),
        .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .retire_pulse_o(retire_pulse), .illegal_pulse_o(illegal_pulse)
    );

    gpr_regfile gpr_regfile_i (
        .clk, .arst_n_i, .rs1_raddr_i(rf_rs1), .rs2_raddr_i(rf_rs2),
        .host_raddr_i(host_raddr), .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .rs1_rdata_o(rs1_rdata), .rs2_rdata_o(rs2_rdata), .host_rdata_o(host_rdata)
    );

endmodule

//--- hw/pipe_pkg.sv
// Shared definitions for the RV32I execution slice
// ALU opcodes, stall/flush bus layout, decode-info layout and APB register map
package pipe_pkg;

    parameter int REG_ADDR_WIDTH = 5;
    parameter int INST_WIDTH     = 32;

    // stall/flush bus
    parameter int CU_BUS_WIDTH = 2;
    parameter int CU_STALL     = 0;
    parameter int CU_FLUSH     = 1;

    // decode info is {use_imm, alu_op}
    parameter int DECINFO_WIDTH = 4;
    parameter int DEC_USE_IMM   = 3;   // bit index of the immediate select

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_LUI = 3'd5
    } alu_op_e;

    // APB register offsets
    parameter logic [7:0] REG_CTRL     = 8'h00;
    parameter logic [7:0] REG_INSTR    = 8'h04;
    parameter logic [7:0] REG_STATUS   = 8'h08;
    parameter logic [7:0] REG_RETIRED  = 8'h0C;
    parameter logic [7:0] REG_GPR_BASE = 8'h80;  // GPR n at base + 4n

endpackage

//--- mini_pipe_top.f
hw/pipe_pkg.sv
hw/apb_ctrl_regs.sv
hw/idu_decode.sv
hw/idu_id_pipe.sv
hw/gpr_regfile.sv
hw/exu_alu_wb.sv
hw/mini_pipe_top.sv
dv/tb_mini_pipe.sv
